// ==== source/cachePkg.sv ====
package cachePkg;

    // --------------------------------------------------
    // Word geometry
    // --------------------------------------------------

    // Data and address word width
    localparam int wordBits = 32;

    // Address bits below the word, byte select
    localparam int byteOffsetBits = 2;

    // --------------------------------------------------
    // Default cache and memory geometry
    // --------------------------------------------------

    // Words per cache block
    localparam int defaultBlockWords = 4;

    // Sets per way
    localparam int defaultLines = 16;

    // Backing memory size, in blocks
    localparam int defaultMemBlocks = 256;

    // Cycles from seen request to acknowledge
    localparam int defaultMemDelay = 3;

    // --------------------------------------------------
    // Memory contents after reset
    // --------------------------------------------------

    // Word contents = byte address ^ initPattern
    localparam logic [wordBits-1:0] initPattern = 32'hA5A5_0000;

endpackage

// ==== source/cacheWay.sv ====
`timescale 1ns/1ps

module cacheWay #(
    parameter int blockWords = cachePkg::defaultBlockWords,
    parameter int lines = cachePkg::defaultLines,
    parameter int tagBits = cachePkg::wordBits - cachePkg::byteOffsetBits
                            - $clog2(blockWords) - $clog2(lines)
) (
    input  logic clk,
    input  logic rstN,
    input  logic [$clog2(lines)-1:0] index,
    input  logic fill,
    input  logic [blockWords*cachePkg::wordBits-1:0] fillBlock,
    input  logic update,
    input  logic [$clog2(blockWords)-1:0] wordSel,
    input  logic [cachePkg::wordBits-1:0] updateWord,
    input  logic [tagBits-1:0] fillTag,
    output logic valid,
    output logic [tagBits-1:0] tag,
    output logic [blockWords*cachePkg::wordBits-1:0] block
);
    import cachePkg::*;

    // Per-set state
    logic [lines-1:0] validBits;
    logic [tagBits-1:0] tagMem [lines];
    logic [blockWords*wordBits-1:0] dataMem [lines];

    // Lookup is purely combinational on index
    assign valid = validBits[index];
    assign tag = tagMem[index];
    assign block = dataMem[index];

    // Valid bits, cleared by reset
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            validBits <= '0;
        end else if (fill) begin
            validBits[index] <= 1'b1;
        end
    end

    // Tag and data storage
    // Word 0 sits in the top slot of a block
    always_ff @(posedge clk) begin
        if (fill) begin
            tagMem[index] <= fillTag;
            dataMem[index] <= fillBlock;
        end else if (update) begin
            dataMem[index][(blockWords-1-int'(wordSel))*wordBits +: wordBits] <= updateWord;
        end
    end

    // Fill comes from a read miss, update from a write hit; never both at once
    fillUpdateExclusive: assert property (@(posedge clk) disable iff (!rstN)
        !(fill && update))
        else $error("cacheWay: fill and update in the same cycle");

endmodule

// ==== source/cacheController.sv ====
`timescale 1ns/1ps

module cacheController (
    input  logic clk,
    input  logic rstN,
    input  logic memRead,
    input  logic memWrite,
    input  logic hit,
    output logic stall,
    output logic fillEn,
    output logic fromMem,
    output logic memReq,
    output logic memWe,
    input  logic memAck
);

    // --------------------------------------------------
    // State encoding
    // --------------------------------------------------

    localparam logic [1:0] stateIdle = 2'd0;
    localparam logic [1:0] stateWaitAck = 2'd1;
    localparam logic [1:0] stateWaitDrop = 2'd2;

    logic [1:0] state;
    logic [1:0] nextState;

    // Memory needed: read miss or any write
    logic needMem;

    assign needMem = memWrite | (memRead & ~hit);

    // --------------------------------------------------
    // Next state
    // --------------------------------------------------

    always_comb begin
        nextState = state;
        case (state)
            stateIdle: begin
                if (needMem) begin
                    nextState = stateWaitAck;
                end
            end
            stateWaitAck: begin
                // Access completes in the ack cycle
                if (memAck) begin
                    nextState = stateWaitDrop;
                end
            end
            stateWaitDrop: begin
                // Four-phase close, wait for memory to release ack
                if (!memAck) begin
                    nextState = stateIdle;
                end
            end
            default: nextState = stateIdle;
        endcase
    end

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            state <= stateIdle;
            memWe <= 1'b0;
        end else begin
            state <= nextState;
            // Direction latched on entry, stable while memReq is high
            if (state == stateIdle && needMem) begin
                memWe <= memWrite;
            end
        end
    end

    // --------------------------------------------------
    // Outputs
    // --------------------------------------------------

    // Request held for the whole wait-ack state
    assign memReq = (state == stateWaitAck);

    always_comb begin
        case (state)
            stateIdle: stall = needMem;
            stateWaitAck: stall = ~memAck;
            // No new access until the handshake has closed
            stateWaitDrop: stall = memRead | memWrite;
            default: stall = 1'b1;
        endcase
    end

    // Single-cycle fill strobe on the read ack
    assign fillEn = (state == stateWaitAck) & memAck & ~memWe;

    // Read data taken from the fetched block
    assign fromMem = (state == stateWaitAck) & ~memWe;

    // Handshake rules seen from the requester side
    reqHeldUntilAck: assert property (@(posedge clk) disable iff (!rstN)
        $fell(memReq) |-> $past(memAck))
        else $error("cacheController: memReq dropped before memAck");

    reqRiseOnlyAckLow: assert property (@(posedge clk) disable iff (!rstN)
        $rose(memReq) |-> !memAck)
        else $error("cacheController: memReq raised while memAck high");

endmodule

// ==== source/dataCache.sv ====
`timescale 1ns/1ps

module dataCache #(
    parameter int blockWords = cachePkg::defaultBlockWords,
    parameter int lines = cachePkg::defaultLines
) (
    input  logic clk,
    input  logic rstN,
    input  logic memRead,
    input  logic memWrite,
    input  logic [cachePkg::wordBits-1:0] addr,
    input  logic [cachePkg::wordBits-1:0] writeData,
    output logic [cachePkg::wordBits-1:0] readData,
    output logic stall,
    output logic memReq,
    output logic memWe,
    output logic [cachePkg::wordBits-1:0] memAddr,
    output logic [cachePkg::wordBits-1:0] memWriteData,
    input  logic memAck,
    input  logic [blockWords*cachePkg::wordBits-1:0] memBlock
);
    import cachePkg::*;

    // --------------------------------------------------
    // Address fields
    // --------------------------------------------------

    localparam int wordSelBits = $clog2(blockWords);
    localparam int indexBits = $clog2(lines);
    localparam int tagBits = wordBits - byteOffsetBits - wordSelBits - indexBits;

    logic [wordSelBits-1:0] wordSel;
    logic [indexBits-1:0] index;
    logic [tagBits-1:0] addrTag;

    assign wordSel = addr[byteOffsetBits +: wordSelBits];
    assign index = addr[byteOffsetBits+wordSelBits +: indexBits];
    assign addrTag = addr[wordBits-1 -: tagBits];

    // Way outputs
    logic valid0, valid1;
    logic [tagBits-1:0] tag0, tag1;
    logic [blockWords*wordBits-1:0] block0, block1;

    // Hit, victim and enables
    logic hit0, hit1, hit;
    logic victim1;
    logic fillEn, fromMem;
    logic fill0, fill1, update0, update1;
    logic [lines-1:0] lruBits;
    logic [wordBits-1:0] word0, word1, memWord;

    cacheWay #(.blockWords(blockWords), .lines(lines), .tagBits(tagBits)) way0 (
        .clk(clk), .rstN(rstN), .index(index),
        .fill(fill0), .fillBlock(memBlock),
        .update(update0), .wordSel(wordSel), .updateWord(writeData),
        .fillTag(addrTag), .valid(valid0), .tag(tag0), .block(block0));

    cacheWay #(.blockWords(blockWords), .lines(lines), .tagBits(tagBits)) way1 (
        .clk(clk), .rstN(rstN), .index(index),
        .fill(fill1), .fillBlock(memBlock),
        .update(update1), .wordSel(wordSel), .updateWord(writeData),
        .fillTag(addrTag), .valid(valid1), .tag(tag1), .block(block1));

    cacheController controller (
        .clk(clk), .rstN(rstN), .memRead(memRead), .memWrite(memWrite),
        .hit(hit), .stall(stall), .fillEn(fillEn), .fromMem(fromMem),
        .memReq(memReq), .memWe(memWe), .memAck(memAck));

    // --------------------------------------------------
    // Hit detection and victim choice
    // --------------------------------------------------

    assign hit0 = valid0 & (tag0 == addrTag);
    assign hit1 = valid1 & (tag1 == addrTag);
    assign hit = hit0 | hit1;

    // Invalid way first, else the one not used last
    assign victim1 = !valid0 ? 1'b0 : (!valid1 ? 1'b1 : ~lruBits[index]);

    assign fill0 = fillEn & ~victim1;
    assign fill1 = fillEn & victim1;

    // Write hit updates in the ack cycle only
    assign update0 = memWrite & hit0 & ~stall;
    assign update1 = memWrite & hit1 & ~stall;

    // LRU bit holds the most recently used way
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            lruBits <= '0;
        end else if ((memRead | memWrite) & hit & ~stall) begin
            lruBits[index] <= hit1;
        end else if (fillEn) begin
            lruBits[index] <= victim1;
        end
    end

    // --------------------------------------------------
    // Word select and read data
    // --------------------------------------------------

    always_comb begin
        word0 = '0;
        word1 = '0;
        memWord = '0;
        for (int w = 0; w < blockWords; w++) begin
            if (int'(wordSel) == w) begin
                word0 = block0[(blockWords-1-w)*wordBits +: wordBits];
                word1 = block1[(blockWords-1-w)*wordBits +: wordBits];
                memWord = memBlock[(blockWords-1-w)*wordBits +: wordBits];
            end
        end
    end

    assign readData = fromMem ? memWord : (hit1 ? word1 : word0);

    // Block-aligned for refills, word-exact for write-through
    assign memAddr = memWe
        ? {addr[wordBits-1:byteOffsetBits], {byteOffsetBits{1'b0}}}
        : {addr[wordBits-1:byteOffsetBits+wordSelBits], {(byteOffsetBits+wordSelBits){1'b0}}};
    assign memWriteData = writeData;

    // A block lives in at most one way
    singleWayHit: assert property (@(posedge clk) disable iff (!rstN)
        (memRead || memWrite) |-> !(hit0 && hit1))
        else $error("dataCache: both ways hit");

    // Refill lands in exactly one way, and only on a miss
    fillOneWay: assert property (@(posedge clk) disable iff (!rstN)
        fillEn |-> ($onehot({fill1, fill0}) && !hit))
        else $error("dataCache: bad fill target");

endmodule

// ==== source/blockMemory.sv ====
`timescale 1ns/1ps

module blockMemory #(
    parameter int blockWords = cachePkg::defaultBlockWords,
    parameter int memBlocks = cachePkg::defaultMemBlocks,
    parameter int memDelay = cachePkg::defaultMemDelay
) (
    input  logic clk,
    input  logic rstN,
    input  logic memReq,
    input  logic memWe,
    input  logic [cachePkg::wordBits-1:0] memAddr,
    input  logic [cachePkg::wordBits-1:0] memWriteData,
    output logic memAck,
    output logic [blockWords*cachePkg::wordBits-1:0] memBlock
);
    import cachePkg::*;

    localparam int memWords = memBlocks * blockWords;
    localparam int wordSelBits = $clog2(blockWords);
    localparam int blockIdxBits = $clog2(memBlocks);
    localparam int countBits = $clog2(memDelay + 1);

    logic [wordBits-1:0] mem [memWords];
    logic [blockIdxBits-1:0] blockIdx;
    logic [blockIdxBits+wordSelBits-1:0] wordIdx;
    logic [countBits-1:0] count;
    logic ackRise;

    // Upper address bits dropped, so addresses wrap
    assign blockIdx = memAddr[byteOffsetBits+wordSelBits +: blockIdxBits];
    assign wordIdx = memAddr[byteOffsetBits +: blockIdxBits+wordSelBits];

    // Contents after reset
    initial begin
        for (int i = 0; i < memWords; i++) begin
            mem[i] = wordBits'(i << byteOffsetBits) ^ initPattern;
        end
    end

    // --------------------------------------------------
    // Four-phase responder
    // --------------------------------------------------

    assign ackRise = memReq & ~memAck & (count == countBits'(memDelay - 1));

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            memAck <= 1'b0;
            count <= '0;
        end else if (memAck) begin
            // Release once the request is gone
            if (!memReq) begin
                memAck <= 1'b0;
            end
        end else if (ackRise) begin
            memAck <= 1'b1;
            count <= '0;
        end else if (memReq) begin
            count <= count + 1'b1;
        end else begin
            count <= '0;
        end
    end

    // Word write lands with the ack
    always @(posedge clk) begin
        if (ackRise && memWe) begin
            mem[wordIdx] <= memWriteData;
        end
    end

    // Block captured with the ack, held while it stays high
    always_ff @(posedge clk) begin
        if (ackRise) begin
            for (int w = 0; w < blockWords; w++) begin
                memBlock[(blockWords-1-w)*wordBits +: wordBits] <=
                    mem[{blockIdx, wordSelBits'(w)}];
            end
        end
    end

    ackNeedsReq: assert property (@(posedge clk) disable iff (!rstN)
        $rose(memAck) |-> $past(memReq))
        else $error("blockMemory: memAck raised without memReq");

endmodule

// ==== source/cacheSystem.sv ====
`timescale 1ns/1ps

module cacheSystem #(
    parameter int blockWords = cachePkg::defaultBlockWords,
    parameter int lines = cachePkg::defaultLines,
    parameter int memBlocks = cachePkg::defaultMemBlocks,
    parameter int memDelay = cachePkg::defaultMemDelay
) (
    input  logic clk,
    input  logic rstN,
    input  logic memRead,
    input  logic memWrite,
    input  logic [cachePkg::wordBits-1:0] addr,
    input  logic [cachePkg::wordBits-1:0] writeData,
    output logic [cachePkg::wordBits-1:0] readData,
    output logic stall
);
    import cachePkg::*;

    // --------------------------------------------------
    // Cache to memory handshake
    // --------------------------------------------------

    logic memReq;
    logic memWe;
    logic memAck;
    logic [wordBits-1:0] memAddr;
    logic [wordBits-1:0] memWriteData;
    logic [blockWords*wordBits-1:0] memBlock;

    // CPU-facing cache
    dataCache #(.blockWords(blockWords), .lines(lines)) i_dataCache (
        .clk(clk), .rstN(rstN),
        .memRead(memRead), .memWrite(memWrite), .addr(addr),
        .writeData(writeData), .readData(readData), .stall(stall),
        .memReq(memReq), .memWe(memWe), .memAddr(memAddr),
        .memWriteData(memWriteData), .memAck(memAck), .memBlock(memBlock));

    // Backing store
    blockMemory #(.blockWords(blockWords), .memBlocks(memBlocks),
                  .memDelay(memDelay)) i_blockMemory (
        .clk(clk), .rstN(rstN),
        .memReq(memReq), .memWe(memWe), .memAddr(memAddr),
        .memWriteData(memWriteData), .memAck(memAck), .memBlock(memBlock));

endmodule

// ==== testbench/cacheSystemTb.sv ====
`timescale 1ns/1ps

module cacheSystemTb;
    import cachePkg::*;

    // --------------------------------------------------
    // Run length and watchdog
    // --------------------------------------------------

    localparam int halfPeriod = 10;
    localparam int clkPeriod = 2 * halfPeriod;
    localparam int resetCycles = 3;
    localparam int directedAccesses = 20;
    localparam int randomAccesses = 300;
    // Per-access budget above the memDelay plus 4 cycles of a miss
    localparam int watchdogTime = (directedAccesses + randomAccesses)
                                  * (defaultMemDelay + 6) * clkPeriod;
    localparam int shadowWords = defaultMemBlocks * defaultBlockWords;

    // DUT ports
    logic clk;
    logic rstN;
    logic memRead;
    logic memWrite;
    logic [wordBits-1:0] addr;
    logic [wordBits-1:0] writeData;
    logic [wordBits-1:0] readData;
    logic stall;

    // Expected memory image and current expected read word
    logic [wordBits-1:0] shadow [shadowWords];
    logic [wordBits-1:0] expectWord;
    logic [31:0] rngState;
    int errorCount;
    int accessCount;

    cacheSystem #(
        .blockWords(defaultBlockWords),
        .lines(defaultLines),
        .memBlocks(defaultMemBlocks),
        .memDelay(defaultMemDelay)
    ) i_cacheSystem (
        .clk(clk), .rstN(rstN),
        .memRead(memRead), .memWrite(memWrite), .addr(addr),
        .writeData(writeData), .readData(readData), .stall(stall));

    always #halfPeriod clk = ~clk;

    // --------------------------------------------------
    // Read data check on every completed read
    // --------------------------------------------------

    readMatchesShadow: assert property (@(posedge clk) disable iff (!rstN)
        (memRead && !stall) |-> (readData == expectWord))
        else begin
            errorCount++;
            $display("CHECK FAILED at %0t: read of %h returned %h, expected %h",
                     $time, $sampled(addr), $sampled(readData), $sampled(expectWord));
        end

    // --------------------------------------------------
    // Helpers
    // --------------------------------------------------

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    // Word slot in the shadow that wraps like the backing memory
    function automatic int shadowIndex(input logic [wordBits-1:0] a);
        return int'((a >> byteOffsetBits) % shadowWords);
    endfunction

    // One access held until stall is seen low before a rising edge
    task automatic issueAccess(input logic isWrite, input logic [wordBits-1:0] a,
                               input logic [wordBits-1:0] d, output logic wasHit);
        @(negedge clk);
        addr = a;
        writeData = d;
        memRead = ~isWrite;
        memWrite = isWrite;
        expectWord = shadow[shadowIndex(a)];
        // Stall is combinational and settles well before the next edge
        #1;
        wasHit = ~stall;
        while (stall) begin
            @(negedge clk);
            #1;
        end
        // Completing edge
        @(posedge clk);
        if (isWrite) begin
            shadow[shadowIndex(a)] = d;
        end
        accessCount++;
        // Bus idle while the memory handshake closes
        @(negedge clk);
        memRead = 1'b0;
        memWrite = 1'b0;
        @(negedge clk);
    endtask

    task automatic readExpect(input logic [wordBits-1:0] a, input logic expectHit);
        logic wasHit;
        issueAccess(1'b0, a, '0, wasHit);
        assert (wasHit == expectHit)
        else begin
            errorCount++;
            $display("CHECK FAILED at %0t: read of %h was a %s, expected a %s",
                     $time, a, wasHit ? "hit" : "miss", expectHit ? "hit" : "miss");
        end
    endtask

    task automatic writeWord(input logic [wordBits-1:0] a, input logic [wordBits-1:0] d);
        logic wasHit;
        issueAccess(1'b1, a, d, wasHit);
        assert (!wasHit)
        else begin
            errorCount++;
            $display("CHECK FAILED at %0t: write to %h completed without a stall",
                     $time, a);
        end
    endtask

    // Four competing blocks in each of sets 2 and 3 keep evictions frequent
    task automatic runRandom(input int count);
        logic [wordBits-1:0] a;
        logic wasHit;
        for (int n = 0; n < count; n++) begin
            rngState = xorshift(rngState);
            a = {20'h0, 2'b10, rngState[2:1], 3'b001, rngState[0], rngState[4:3], 2'b00};
            if (rngState[7:5] < 3'd3) begin
                rngState = xorshift(rngState);
                writeWord(a, rngState);
            end else begin
                issueAccess(1'b0, a, '0, wasHit);
            end
        end
    endtask

    // Watchdog
    initial begin
        #(watchdogTime);
        $display("Timeout: run did not finish within %0d ns", watchdogTime);
        $display("Test failed");
        $finish;
    end

    // --------------------------------------------------
    // Main sequence
    // --------------------------------------------------

    initial begin
        clk = 1'b0;
        rstN = 1'b0;
        memRead = 1'b0;
        memWrite = 1'b0;
        addr = '0;
        writeData = '0;
        expectWord = '0;
        errorCount = 0;
        accessCount = 0;
        rngState = 32'd10366;
        // Memory image after reset
        for (int i = 0; i < shadowWords; i++) begin
            shadow[i] = wordBits'(i << byteOffsetBits) ^ initPattern;
        end

        repeat (resetCycles) @(posedge clk);
        @(negedge clk);
        rstN = 1'b1;
        #1;
        assert (!stall)
        else begin
            errorCount++;
            $display("CHECK FAILED at %0t: stall high while idle after reset", $time);
        end

        // First touches miss
        readExpect(32'h0000_0100, 1'b0);
        readExpect(32'h0000_00C4, 1'b0);

        // Same block hits
        readExpect(32'h0000_0104, 1'b1);
        readExpect(32'h0000_010C, 1'b1);
        readExpect(32'h0000_0100, 1'b1);
        readExpect(32'h0000_00C8, 1'b1);

        // Write hit then eviction and refetch from memory
        writeWord(32'h0000_0108, 32'hDEAD_BEEF);
        readExpect(32'h0000_0108, 1'b1);
        readExpect(32'h0000_0200, 1'b0);
        readExpect(32'h0000_0300, 1'b0);
        readExpect(32'h0000_0108, 1'b0);
        readExpect(32'h0000_010C, 1'b1);
        // Write miss goes to memory only
        writeWord(32'h0000_0700, 32'h1234_5678);
        readExpect(32'h0000_0700, 1'b0);

        // A B A C in set 1 keeps A and drops B under LRU
        readExpect(32'h0000_0410, 1'b0);
        readExpect(32'h0000_0510, 1'b0);
        readExpect(32'h0000_0410, 1'b1);
        readExpect(32'h0000_0610, 1'b0);
        readExpect(32'h0000_0410, 1'b1);
        readExpect(32'h0000_0510, 1'b0);

        runRandom(randomAccesses);

        @(negedge clk);
        memRead = 1'b0;
        memWrite = 1'b0;
        repeat (2) @(negedge clk);

        $display("Accesses: %0d, errors: %0d", accessCount, errorCount);
        if (errorCount == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

// ==== verilog.f ====
source/cachePkg.sv
source/cacheWay.sv
source/cacheController.sv
source/dataCache.sv
source/blockMemory.sv
source/cacheSystem.sv
testbench/cacheSystemTb.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the cache testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    --top-module cacheSystemTb -f verilog.f -o simCacheSystem

output=$(./obj_dir/simCacheSystem)
echo "$output"

if echo "$output" | grep -qx "Test passed"; then
    exit 0
fi
exit 1
